// ==== verilog/rvIsaPkg.sv ====
// RV32I base encodings only. No M extension, no CSR, fence or system opcodes.
// memSizeE values line up with funct3[1:0] of loads and stores.
package rvIsaPkg;

  typedef logic [6:0] opcodeT;
  typedef logic [2:0] funct3T;
  typedef logic [6:0] funct7T;

  localparam opcodeT OP_COMPUTE  = 7'b0110011; // R-type
  localparam opcodeT OP_ICOMPUTE = 7'b0010011; // register-immediate
  localparam opcodeT OP_LOAD     = 7'b0000011;
  localparam opcodeT OP_STORE    = 7'b0100011;
  localparam opcodeT OP_BRANCH   = 7'b1100011;
  localparam opcodeT OP_JAL      = 7'b1101111;
  localparam opcodeT OP_JALR     = 7'b1100111;
  localparam opcodeT OP_LUI      = 7'b0110111;
  localparam opcodeT OP_AUIPC    = 7'b0010111;

  localparam funct7T F7_BASE = 7'h00;
  localparam funct7T F7_ALT  = 7'h20; // sub and sra

  // integer ops, same funct3 in R and I forms
  localparam funct3T F3_ADD  = 3'b000;
  localparam funct3T F3_SLL  = 3'b001;
  localparam funct3T F3_SLT  = 3'b010;
  localparam funct3T F3_SLTU = 3'b011;
  localparam funct3T F3_XOR  = 3'b100;
  localparam funct3T F3_SR   = 3'b101; // srl or sra
  localparam funct3T F3_OR   = 3'b110;
  localparam funct3T F3_AND  = 3'b111;

  localparam funct3T F3_BEQ  = 3'b000;
  localparam funct3T F3_BNE  = 3'b001;
  localparam funct3T F3_BLT  = 3'b100;
  localparam funct3T F3_BGE  = 3'b101;
  localparam funct3T F3_BLTU = 3'b110;
  localparam funct3T F3_BGEU = 3'b111;

  // load and store widths
  localparam funct3T F3_BYTE   = 3'b000;
  localparam funct3T F3_HALF   = 3'b001;
  localparam funct3T F3_WORD   = 3'b010;
  localparam funct3T F3_BYTE_U = 3'b100;
  localparam funct3T F3_HALF_U = 3'b101;

  typedef enum logic [2:0] {IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J, IMM_SHIFT} immKindE;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } aluOpE;

  typedef enum logic [2:0] {
    BR_NEVER, BR_ALWAYS, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU
  } branchOpE;

  typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC4, WB_IMM} wbSelE;

  typedef enum logic [1:0] {SIZE_BYTE = 2'b00, SIZE_HALF = 2'b01, SIZE_WORD = 2'b10} memSizeE;

  typedef enum logic [1:0] {
    FAULT_NONE, FAULT_ILLEGAL, FAULT_MEM_ALIGN, FAULT_PC_ALIGN
  } faultE;

endpackage

// ==== verilog/execPkg.sv ====
// Datapath widths and the records passed between the stages.
// QUEUE_DEPTH must be a power of two and fit in CREDIT_W bits.
package execPkg;
  import rvIsaPkg::*;

  localparam int unsigned XLEN        = 32;
  localparam int unsigned REG_ADDR_W  = 5;
  localparam int unsigned SHAMT_W     = $clog2(XLEN);
  localparam int unsigned QUEUE_DEPTH = 4; // also the input credits after reset
  localparam int unsigned QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int unsigned CREDIT_W    = 3;

  typedef logic [XLEN-1:0]        wordT;
  typedef logic [REG_ADDR_W-1:0]  regAddrT;
  typedef logic [QUEUE_PTR_W-1:0] queuePtrT;
  typedef logic [CREDIT_W-1:0]    creditT;

  typedef struct packed {
    wordT instWord;
    wordT pc;
    wordT rs1Val;
    wordT rs2Val;
  } instReqT;

  typedef struct packed {
    aluOpE    aluOp;
    branchOpE branchOp;
    wordT     opA;
    wordT     opB;
    wordT     rs1Val; // branch compare operands
    wordT     rs2Val;
    wordT     imm;
    wordT     pc;
    regAddrT  rd;
    logic     regWrite;
    wbSelE    wbSel;
    logic     memRead;
    logic     memWrite;
    memSizeE  memSize;
    logic     illegal;
  } decodedT;

  typedef struct packed {
    wordT    result; // writeback value, or the address for loads and stores
    wordT    nextPc;
    regAddrT rd;
    logic    regWrite;
    logic    memRead;
    logic    memWrite;
    memSizeE memSize;
    faultE   fault;
  } execResultT;

endpackage

// ==== verilog/instDecoder.sv ====
`timescale 1ns/1ns
// Stage one. Takes one instruction per cycle and never stalls.
// Controls of an illegal word are kept as decoded; stage two raises the fault.
module instDecoder
  import execPkg::*, rvIsaPkg::*;
(
  input  logic    clk,
  input  logic    rstN,
  input  logic    inValid,
  input  instReqT inReq,
  output logic    stage1Valid,
  output decodedT stage1
);

  wordT     inst;
  opcodeT   opcode;
  funct3T   funct3;
  funct7T   funct7;
  aluOpE    intAluOp;
  immKindE  immKind;
  logic     aSelPc;  // operand A from pc
  logic     bSelImm; // operand B from the immediate
  wordT     imm;
  decodedT  dec;

  assign inst   = inReq.instWord;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // R and I forms share this map, bit 30 picks sub/sra
  always_comb begin
    case (funct3)
      F3_ADD:  intAluOp = (funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
      F3_SLL:  intAluOp = ALU_SLL;
      F3_SLT:  intAluOp = ALU_SLT;
      F3_SLTU: intAluOp = ALU_SLTU;
      F3_XOR:  intAluOp = ALU_XOR;
      F3_SR:   intAluOp = inst[30] ? ALU_SRA : ALU_SRL;
      F3_OR:   intAluOp = ALU_OR;
      default: intAluOp = ALU_AND;
    endcase
  end

  always_comb begin
    dec          = '0;
    dec.aluOp    = ALU_ADD;
    dec.branchOp = BR_NEVER;
    dec.wbSel    = WB_ALU;
    dec.memSize  = SIZE_WORD;
    immKind      = IMM_NONE;
    aSelPc       = 1'b0;
    bSelImm      = 1'b0;
    case (opcode)
      OP_COMPUTE: begin
        dec.regWrite = 1'b1;
        dec.aluOp    = intAluOp;
        if (funct3 == F3_ADD || funct3 == F3_SR)
          dec.illegal = (funct7 != F7_BASE) && (funct7 != F7_ALT);
        else
          dec.illegal = (funct7 != F7_BASE);
      end
      OP_ICOMPUTE: begin
        dec.regWrite = 1'b1;
        dec.aluOp    = (funct3 == F3_ADD) ? ALU_ADD : intAluOp; // no subi
        immKind      = (funct3 == F3_SLL || funct3 == F3_SR) ? IMM_SHIFT : IMM_I;
        bSelImm      = 1'b1;
      end
      OP_LOAD: begin
        dec.regWrite = 1'b1;
        dec.memRead  = 1'b1;
        dec.wbSel    = WB_MEM;
        immKind      = IMM_I;
        bSelImm      = 1'b1;
        case (funct3)
          F3_BYTE, F3_BYTE_U: dec.memSize = SIZE_BYTE;
          F3_HALF, F3_HALF_U: dec.memSize = SIZE_HALF;
          F3_WORD:            dec.memSize = SIZE_WORD;
          default:            dec.illegal = 1'b1;
        endcase
      end
      OP_STORE: begin
        dec.memWrite = 1'b1;
        dec.wbSel    = WB_MEM; // report the address
        immKind      = IMM_S;
        bSelImm      = 1'b1;
        case (funct3)
          F3_BYTE: dec.memSize = SIZE_BYTE;
          F3_HALF: dec.memSize = SIZE_HALF;
          F3_WORD: dec.memSize = SIZE_WORD;
          default: dec.illegal = 1'b1;
        endcase
      end
      OP_BRANCH: begin
        immKind = IMM_B;
        aSelPc  = 1'b1; // target is pc + imm
        bSelImm = 1'b1;
        case (funct3)
          F3_BEQ:  dec.branchOp = BR_EQ;
          F3_BNE:  dec.branchOp = BR_NE;
          F3_BLT:  dec.branchOp = BR_LT;
          F3_BGE:  dec.branchOp = BR_GE;
          F3_BLTU: dec.branchOp = BR_LTU;
          F3_BGEU: dec.branchOp = BR_GEU;
          default: dec.illegal  = 1'b1;
        endcase
      end
      OP_JAL: begin
        dec.regWrite = 1'b1;
        dec.branchOp = BR_ALWAYS;
        dec.wbSel    = WB_PC4;
        immKind      = IMM_J;
        aSelPc       = 1'b1;
        bSelImm      = 1'b1;
      end
      OP_JALR: begin
        dec.regWrite = 1'b1;
        dec.branchOp = BR_ALWAYS;
        dec.wbSel    = WB_PC4;
        immKind      = IMM_I;
        bSelImm      = 1'b1; // target is rs1 + imm
      end
      OP_LUI: begin
        dec.regWrite = 1'b1;
        dec.wbSel    = WB_IMM; // ALU result unused
        immKind      = IMM_U;
      end
      OP_AUIPC: begin
        dec.regWrite = 1'b1;
        immKind      = IMM_U;
        aSelPc       = 1'b1;
        bSelImm      = 1'b1;
      end
      default: dec.illegal = 1'b1; // unknown opcode
    endcase
    dec.imm    = imm;
    dec.pc     = inReq.pc;
    dec.rs1Val = inReq.rs1Val;
    dec.rs2Val = inReq.rs2Val;
    dec.opA    = aSelPc ? inReq.pc : inReq.rs1Val;
    dec.opB    = bSelImm ? imm : inReq.rs2Val;
    dec.rd     = inst[11:7];
  end

  always_comb begin
    case (immKind)
      IMM_I:     imm = {{20{inst[31]}}, inst[31:20]};
      IMM_S:     imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      IMM_B:     imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      IMM_U:     imm = {inst[31:12], 12'b0};
      IMM_J:     imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      IMM_SHIFT: imm = {27'b0, inst[24:20]}; // shamt only
      default:   imm = '0;
    endcase
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      stage1Valid <= 1'b0;
    else
      stage1Valid <= inValid;
  end

  always_ff @(posedge clk) begin
    if (inValid)
      stage1 <= dec;
  end

endmodule

// ==== verilog/execStage.sv ====
`timescale 1ns/1ns
// Stage two. ALU, branch decision and alignment checks, one record per cycle.
// Any fault clears regWrite and memWrite. memRead is passed as decoded.
module execStage
  import execPkg::*, rvIsaPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       stage1Valid,
  input  decodedT    stage1,
  output logic       stage2Valid,
  output execResultT stage2
);

  wordT               aluOut;
  logic [SHAMT_W-1:0] shamt;
  logic               taken;
  wordT               pcPlus4;
  wordT               memAddr;
  logic               memMisaligned;
  logic               pcMisaligned;
  execResultT         res;

  assign shamt   = stage1.opB[SHAMT_W-1:0]; // low 5 bits only
  assign pcPlus4 = stage1.pc + wordT'(4);
  assign memAddr = aluOut; // effective address of loads and stores

  always_comb begin
    case (stage1.aluOp)
      ALU_ADD:  aluOut = stage1.opA + stage1.opB;
      ALU_SUB:  aluOut = stage1.opA - stage1.opB;
      ALU_SLL:  aluOut = stage1.opA << shamt;
      ALU_SLT:  aluOut = wordT'($signed(stage1.opA) < $signed(stage1.opB));
      ALU_SLTU: aluOut = wordT'(stage1.opA < stage1.opB);
      ALU_XOR:  aluOut = stage1.opA ^ stage1.opB;
      ALU_SRL:  aluOut = stage1.opA >> shamt;
      ALU_SRA:  aluOut = wordT'($signed(stage1.opA) >>> shamt);
      ALU_OR:   aluOut = stage1.opA | stage1.opB;
      default:  aluOut = stage1.opA & stage1.opB;
    endcase
  end

  // compares the source registers, never the ALU operands
  always_comb begin
    case (stage1.branchOp)
      BR_ALWAYS: taken = 1'b1;
      BR_EQ:     taken = (stage1.rs1Val == stage1.rs2Val);
      BR_NE:     taken = (stage1.rs1Val != stage1.rs2Val);
      BR_LT:     taken = ($signed(stage1.rs1Val) < $signed(stage1.rs2Val));
      BR_GE:     taken = ($signed(stage1.rs1Val) >= $signed(stage1.rs2Val));
      BR_LTU:    taken = (stage1.rs1Val < stage1.rs2Val);
      BR_GEU:    taken = (stage1.rs1Val >= stage1.rs2Val);
      default:   taken = 1'b0;
    endcase
  end

  always_comb begin
    memMisaligned = 1'b0;
    if (stage1.memRead || stage1.memWrite) begin
      case (stage1.memSize)
        SIZE_HALF: memMisaligned = memAddr[0];
        SIZE_WORD: memMisaligned = (memAddr[1:0] != 2'b00);
        default:   memMisaligned = 1'b0; // bytes always aligned
      endcase
    end
  end

  assign pcMisaligned = taken && (aluOut[1:0] != 2'b00);

  always_comb begin
    res          = '0;
    res.nextPc   = taken ? aluOut : pcPlus4;
    res.rd       = stage1.rd;
    res.regWrite = stage1.regWrite;
    res.memRead  = stage1.memRead;
    res.memWrite = stage1.memWrite;
    res.memSize  = stage1.memSize;
    case (stage1.wbSel)
      WB_MEM:  res.result = memAddr;
      WB_PC4:  res.result = pcPlus4; // link address
      WB_IMM:  res.result = stage1.imm;
      default: res.result = aluOut;
    endcase
    if (stage1.illegal)
      res.fault = FAULT_ILLEGAL;
    else if (memMisaligned)
      res.fault = FAULT_MEM_ALIGN;
    else if (pcMisaligned)
      res.fault = FAULT_PC_ALIGN;
    else
      res.fault = FAULT_NONE;
    if (res.fault != FAULT_NONE) begin
      res.regWrite = 1'b0;
      res.memWrite = 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)
      stage2Valid <= 1'b0;
    else
      stage2Valid <= stage1Valid;
  end

  always_ff @(posedge clk) begin
    if (stage1Valid)
      stage2 <= res;
  end

endmodule

// ==== verilog/resultQueue.sv ====
`timescale 1ns/1ns
// Result FIFO with credit flow on both sides. Never refuses a write.
// Upstream credits keep it from overflowing. Downstream may hold at most
// 2**CREDIT_W-1 unspent output credits.
module resultQueue
  import execPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       stage2Valid,
  input  execResultT stage2,
  input  logic       outCredit,
  output logic       outValid,
  output execResultT outResult,
  output logic       inCredit
);

  execResultT mem [QUEUE_DEPTH];
  queuePtrT   wrPtr;
  queuePtrT   rdPtr;
  creditT     level;      // records held
  creditT     outCredits; // sends allowed by downstream
  logic       send;

  assign send      = (level != '0) && (outCredits != '0);
  assign outValid  = send;
  assign outResult = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (stage2Valid)
      mem[wrPtr] <= stage2;
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      level <= '0;
    end else begin
      if (stage2Valid)
        wrPtr <= wrPtr + 1'b1; // wraps, depth is a power of two
      if (send)
        rdPtr <= rdPtr + 1'b1;
      case ({stage2Valid, send})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      outCredits <= '0;
      inCredit   <= 1'b0;
    end else begin
      case ({outCredit, send})
        2'b10:   outCredits <= outCredits + 1'b1;
        2'b01:   outCredits <= outCredits - 1'b1;
        default: outCredits <= outCredits;
      endcase
      inCredit <= send; // slot freed, credit goes back a cycle later
    end
  end

endmodule

// ==== verilog/execUnit.sv ====
`timescale 1ns/1ns
// RV32I decode-and-execute unit, credit flow on both sides.
// Upstream starts with QUEUE_DEPTH credits, the unit with no output credits.
module execUnit
  import execPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       inValid,
  input  instReqT    inReq,
  output logic       inCredit,
  output logic       outValid,
  output execResultT outResult,
  input  logic       outCredit
);

  logic       stage1Valid;
  decodedT    stage1;
  logic       stage2Valid;
  execResultT stage2;

  instDecoder u_instDecoder (
    .clk         (clk),
    .rstN        (rstN),
    .inValid     (inValid),
    .inReq       (inReq),
    .stage1Valid (stage1Valid),
    .stage1      (stage1)
  );

  execStage u_execStage (
    .clk         (clk),
    .rstN        (rstN),
    .stage1Valid (stage1Valid),
    .stage1      (stage1),
    .stage2Valid (stage2Valid),
    .stage2      (stage2)
  );

  resultQueue u_resultQueue (
    .clk         (clk),
    .rstN        (rstN),
    .stage2Valid (stage2Valid),
    .stage2      (stage2),
    .outCredit   (outCredit),
    .outValid    (outValid),
    .outResult   (outResult),
    .inCredit    (inCredit)
  );

endmodule

// ==== bench/tbClock.sv ====
`timescale 1ns/1ns
// Clock and reset for the testbench. 4 ns period.
// rstN is held low for the first 8 rising edges, then released on an edge.
module tbClock (
  output logic clk,
  output logic rstN
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // half period
  end

  initial begin
    rstN <= 1'b0;
    repeat (8) @(posedge clk);
    rstN <= 1'b1;
  end

endmodule

// ==== bench/resultChecker.sv ====
`timescale 1ns/1ns
// Matches each sent record against the next expected one, in issue order.
// Also watches both credit paths for sends or returns with no cover.
module resultChecker
  import execPkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic       pushValid,
  input  execResultT pushRecord,
  input  logic       outValid,
  input  execResultT outResult,
  input  logic       outCredit,
  input  logic       inCredit,
  output int         checked,
  output int         errors
);

  execResultT expQ[$];
  int         granted;  // output credits seen
  int         sent;     // records seen on outValid
  int         returned; // inCredit pulses seen

  // first field that differs, for the error line
  function automatic string diffField(input execResultT got, input execResultT exp);
    if (got.result !== exp.result)
      return "result";
    if (got.nextPc !== exp.nextPc)
      return "nextPc";
    if (got.rd !== exp.rd)
      return "rd";
    if (got.regWrite !== exp.regWrite)
      return "regWrite";
    if (got.memRead !== exp.memRead)
      return "memRead";
    if (got.memWrite !== exp.memWrite)
      return "memWrite";
    if (got.memSize !== exp.memSize)
      return "memSize";
    return "fault";
  endfunction

  always @(posedge clk) begin
    execResultT exp;
    if (rstN) begin
      if (pushValid)
        expQ.push_back(pushRecord);
      if (inCredit && returned >= sent) begin
        $display("input credit returned at %0t ns with no record sent for it", $time);
        errors++;
      end
      if (inCredit)
        returned++;
      if (outValid) begin
        if (sent >= granted) begin // send must be covered by an earlier grant
          $display("record sent at %0t ns without an output credit", $time);
          errors++;
        end
        sent++;
        if (expQ.size() == 0) begin
          $display("extra record at %0t ns, nothing was left to expect", $time);
          errors++;
        end else begin
          exp = expQ.pop_front();
          checked++;
          if (outResult !== exp) begin
            $display("** Error at %0t ns: test %0d %s mismatch, got %h expected %h",
                     $time, checked, diffField(outResult, exp), outResult, exp);
            errors++;
          end else begin
            $display("test %0d ok, result %h nextPc %h", checked, outResult.result,
                     outResult.nextPc);
          end
        end
      end
      if (outCredit)
        granted++; // usable from the next edge on
    end
  end

endmodule

// ==== bench/execUnitTb.sv ====
`timescale 1ns/1ns
// Runs a hand-worked table of RV32I instructions through execUnit.
// Upstream keeps its own credit count; downstream grants credits at random gaps.
module execUnitTb
  import execPkg::*, rvIsaPkg::*;
();

  logic       clk;
  logic       rstN;
  logic       inValid;
  instReqT    inReq;
  logic       inCredit;
  logic       outValid;
  execResultT outResult;
  logic       outCredit;
  logic       pushValid;
  execResultT pushRecord;
  int         checked;
  int         errors;
  int         rows;
  instReqT    reqTable[$];
  execResultT expTable[$];

  tbClock u_tbClock (.clk(clk), .rstN(rstN));

  execUnit u_execUnit (
    .clk       (clk),
    .rstN      (rstN),
    .inValid   (inValid),
    .inReq     (inReq),
    .inCredit  (inCredit),
    .outValid  (outValid),
    .outResult (outResult),
    .outCredit (outCredit)
  );

  resultChecker u_resultChecker (
    .clk        (clk),
    .rstN       (rstN),
    .pushValid  (pushValid),
    .pushRecord (pushRecord),
    .outValid   (outValid),
    .outResult  (outResult),
    .outCredit  (outCredit),
    .inCredit   (inCredit),
    .checked    (checked),
    .errors     (errors)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // flags are {regWrite, memRead, memWrite, memSize}
  task automatic addRow(input wordT inst, input wordT pc, input wordT a, input wordT b,
                        input wordT result, input wordT nextPc, input regAddrT rd,
                        input logic [4:0] flags, input faultE fault);
    instReqT    req;
    execResultT exp;
    req.instWord = inst;
    req.pc       = pc;
    req.rs1Val   = a;
    req.rs2Val   = b;
    exp.result   = result;
    exp.nextPc   = nextPc;
    exp.rd       = rd;
    exp.regWrite = flags[4];
    exp.memRead  = flags[3];
    exp.memWrite = flags[2];
    exp.memSize  = memSizeE'(flags[1:0]);
    exp.fault    = fault;
    reqTable.push_back(req);
    expTable.push_back(exp);
  endtask

  task automatic loadTable();
    // inst         pc      rs1Val       rs2Val  result        nextPc   rd     flags
    addRow('h002081b3, 'h100, 5, 7, 12, 'h104, 5'd3, 5'b100_10, FAULT_NONE); // add
    addRow('h402081b3, 'h104, 5, 7, -2, 'h108, 5'd3, 5'b100_10, FAULT_NONE); // sub
    addRow('h002091b3, 'h108, 3, 'h23, 'h18, 'h10c, 5'd3, 5'b100_10, FAULT_NONE); // sll
    addRow('h0020a1b3, 'h10c, -1, 1, 1, 'h110, 5'd3, 5'b100_10, FAULT_NONE); // slt
    addRow('h0020b1b3, 'h110, -1, 1, 0, 'h114, 5'd3, 5'b100_10, FAULT_NONE); // sltu
    addRow('h0020d1b3, 'h114, 'h80000000, 4, 'h08000000, 'h118, 5'd3, 5'b100_10,
           FAULT_NONE); // srl
    addRow('h0020e1b3, 'h118, 'hf0, 'h0f, 'hff, 'h11c, 5'd3, 5'b100_10, FAULT_NONE); // or
    addRow('h0020c1b3, 'h130, 'hff, 'h0f, 'hf0, 'h134, 5'd3, 5'b100_10, FAULT_NONE); // xor
    addRow('h0020f1b3, 'h134, 'hf0, 'h3c, 'h30, 'h138, 5'd3, 5'b100_10, FAULT_NONE); // and
    addRow('h4020d1b3, 'h138, 'h80000000, 4, 'hf8000000, 'h13c, 5'd3, 5'b100_10,
           FAULT_NONE); // sra
    addRow('h0f00c193, 'h11c, 'hfff, 0, 'hf0f, 'h120, 5'd3, 5'b100_10, FAULT_NONE); // xori
    addRow('h4040d193, 'h120, 'h80000000, 0, 'hf8000000, 'h124, 5'd3, 5'b100_10,
           FAULT_NONE); // srai 4
    addRow('hff00f193, 'h124, 'h12345678, 0, 'h12345670, 'h128, 5'd3, 5'b100_10,
           FAULT_NONE); // andi -16
    addRow('h00809193, 'h128, 'hab, 0, 'hab00, 'h12c, 5'd3, 5'b100_10, FAULT_NONE); // slli
    addRow('hfff08193, 'h140, 5, 0, 4, 'h144, 5'd3, 5'b100_10, FAULT_NONE); // addi -1
    addRow('h0010a193, 'h144, -3, 0, 1, 'h148, 5'd3, 5'b100_10, FAULT_NONE); // slti 1
    addRow('h0010b193, 'h148, -3, 0, 0, 'h14c, 5'd3, 5'b100_10, FAULT_NONE); // sltiu 1
    addRow('h00f0e193, 'h14c, 'hf0, 0, 'hff, 'h150, 5'd3, 5'b100_10, FAULT_NONE); // ori
    addRow('h0040d193, 'h150, 'h80000000, 0, 'h08000000, 'h154, 5'd3, 5'b100_10,
           FAULT_NONE); // srli 4
    addRow('h123451b7, 'h200, 0, 0, 'h12345000, 'h204, 5'd3, 5'b100_10, FAULT_NONE); // lui
    addRow('h00001197, 'h204, 0, 0, 'h1204, 'h208, 5'd3, 5'b100_10, FAULT_NONE); // auipc
    addRow('h008000ef, 'h300, 0, 0, 'h304, 'h308, 5'd1, 5'b100_10, FAULT_NONE); // jal +8
    addRow('h004100e7, 'h304, 'h1000, 0, 'h308, 'h1004, 5'd1, 5'b100_10, FAULT_NONE); // jalr
    // branches report the target as result
    addRow('h00208863, 'h400, 9, 9, 'h410, 'h410, 5'd16, 5'b000_10, FAULT_NONE); // beq
    addRow('h00209863, 'h410, 9, 9, 'h420, 'h414, 5'd16, 5'b000_10, FAULT_NONE); // bne
    addRow('hfe20cce3, 'h420, -5, 3, 'h418, 'h418, 5'd25, 5'b000_10, FAULT_NONE); // blt
    addRow('h0020c863, 'h418, 3, -5, 'h428, 'h41c, 5'd16, 5'b000_10, FAULT_NONE); // blt
    addRow('h0020f863, 'h41c, 3, -5, 'h42c, 'h420, 5'd16, 5'b000_10, FAULT_NONE); // bgeu
    addRow('h0020f863, 'h420, -5, 3, 'h430, 'h430, 5'd16, 5'b000_10, FAULT_NONE); // bgeu
    addRow('h00208863, 'h440, 9, 8, 'h450, 'h444, 5'd16, 5'b000_10, FAULT_NONE); // beq
    addRow('h00209863, 'h444, 9, 8, 'h454, 'h454, 5'd16, 5'b000_10, FAULT_NONE); // bne
    addRow('h0020d863, 'h448, -5, 3, 'h458, 'h44c, 5'd16, 5'b000_10, FAULT_NONE); // bge
    addRow('h0020d863, 'h44c, 3, -5, 'h45c, 'h45c, 5'd16, 5'b000_10, FAULT_NONE); // bge
    addRow('h0020e863, 'h450, 3, -5, 'h460, 'h460, 5'd16, 5'b000_10, FAULT_NONE); // bltu
    addRow('h0020e863, 'h454, -5, 3, 'h464, 'h458, 5'd16, 5'b000_10, FAULT_NONE); // bltu
    addRow('h0080a183, 'h500, 'h1000, 0, 'h1008, 'h504, 5'd3, 5'b110_10, FAULT_NONE); // lw
    addRow('h00209323, 'h504, 'h1000, 'h55, 'h1006, 'h508, 5'd6, 5'b001_01, FAULT_NONE); // sh
    addRow('h002080a3, 'h508, 'h1000, 'h55, 'h1001, 'h50c, 5'd1, 5'b001_00, FAULT_NONE); // sb
    addRow('h00309183, 'h50c, 'h1000, 0, 'h1003, 'h510, 5'd3, 5'b010_01,
           FAULT_MEM_ALIGN); // lh odd address
    addRow('h0020a123, 'h510, 'h1000, 'h55, 'h1002, 'h514, 5'd2, 5'b000_10,
           FAULT_MEM_ALIGN); // sw address 2 mod 4
    addRow('h0000007f, 'h600, 0, 0, 0, 'h604, 5'd0, 5'b000_10, FAULT_ILLEGAL); // opcode
    addRow('h022081b3, 'h604, 0, 0, 0, 'h608, 5'd3, 5'b000_10, FAULT_ILLEGAL); // funct7
    addRow('h0080b183, 'h608, 'h1000, 0, 'h1008, 'h60c, 5'd3, 5'b010_10,
           FAULT_ILLEGAL); // load funct3 3
    addRow('h0020c123, 'h60c, 'h1000, 0, 'h1002, 'h610, 5'd2, 5'b000_10,
           FAULT_ILLEGAL); // store funct3 4
    addRow('h002100e7, 'h610, 'h2000, 0, 'h614, 'h2002, 5'd1, 5'b000_10,
           FAULT_PC_ALIGN); // jalr to 2 mod 4
  endtask

  // upstream driver, spends one credit per row
  initial begin
    int credits;
    int rowIdx;
    inValid    <= 1'b0;
    inReq      <= '0;
    pushValid  <= 1'b0;
    pushRecord <= '0;
    loadTable();
    rows    = reqTable.size();
    credits = QUEUE_DEPTH;
    rowIdx  = 0;
    @(posedge rstN);
    while (rowIdx < rows) begin
      @(posedge clk);
      if (inCredit)
        credits++;
      if (credits > 0) begin
        inValid    <= 1'b1;
        inReq      <= reqTable[rowIdx];
        pushValid  <= 1'b1;
        pushRecord <= expTable[rowIdx];
        credits--;
        rowIdx++;
      end else begin
        inValid   <= 1'b0;
        pushValid <= 1'b0;
      end
    end
    @(posedge clk);
    inValid   <= 1'b0;
    pushValid <= 1'b0;
    wait (checked == rows);
    repeat (10) @(posedge clk); // room for a stray extra record
    $display("checked %0d of %0d records, %0d errors", checked, rows, errors);
    if (errors == 0 && checked == rows)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  end

  // downstream, grants with gaps of 0 to 3 cycles
  initial begin
    logic [31:0] rng;
    int          gap;
    int          unspent; // keeps the unit's credit counter in range
    outCredit <= 1'b0;
    rng     = 32'h1174;
    gap     = 0;
    unspent = 0;
    @(posedge rstN);
    forever begin
      @(posedge clk);
      if (outValid)
        unspent--;
      if (gap == 0 && unspent < int'(QUEUE_DEPTH)) begin
        outCredit <= 1'b1;
        unspent++;
        rng = xorshift(rng);
        gap = int'(rng[1:0]);
      end else begin
        outCredit <= 1'b0;
        if (gap > 0)
          gap--;
      end
    end
  end

  initial begin
    @(posedge rstN);
    repeat (rows * 20) @(posedge clk);
    $display("timeout, only %0d of %0d results arrived", checked, rows);
    $display("TB FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
verilog/rvIsaPkg.sv
verilog/execPkg.sv
verilog/instDecoder.sv
verilog/execStage.sv
verilog/resultQueue.sv
verilog/execUnit.sv
bench/tbClock.sv
bench/resultChecker.sv
bench/execUnitTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Compiles the testbench with Verilator and runs it once.
# Exit status is 0 only when the simulation reports a pass.
cd "$(dirname "$0")" || exit 1

verilator --binary --top-module execUnitTb -f verilog.f -o execUnitSim \
  && ./obj_dir/execUnitSim | tee /dev/stderr | grep -qx "TB PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
